//--- common/isa_pkg.sv
package isa_pkg;

	// ==================================================
	// Opcode field
	// ==================================================

	// Seven-bit major opcode in instruction bits 6..0
	typedef logic [6:0] opcode_t;

	// Control-transfer opcodes, anything else is an ordinary instruction
	localparam opcode_t OP_NOP = 7'h0B;
	// Branch to subroutine, relative
	localparam opcode_t OP_BSR = 7'h20;
	// Unconditional branch, relative
	localparam opcode_t OP_BRA = 7'h21;
	// Jump to subroutine, absolute
	localparam opcode_t OP_JSR = 7'h22;
	// Jump, absolute
	localparam opcode_t OP_JMP = 7'h23;
	// Conditional branch, relative
	localparam opcode_t OP_BCC = 7'h24;
	// Return from subroutine
	localparam opcode_t OP_RTD = 7'h25;

	// ==================================================
	// Instruction layout
	// ==================================================

	// Three 16-bit parcels per instruction slot
	typedef struct packed {
		// Displacement or absolute target for transfers
		logic [39:0] operand;
		// Reserved, always zero for now
		logic        rsvd;
		opcode_t     opcode;
	} instr_t;

	// Filler parcel used past the end of the cache line
	localparam logic [15:0] NOP_PARCEL = {9'd0, OP_NOP};

	// A whole slot of NOP parcels
	// Same bit pattern the aligner produces in the padded area
	localparam instr_t NOP_INSN = instr_t'({3{NOP_PARCEL}});

	// ==================================================
	// Per-slot decode result
	// ==================================================

	// One flag per transfer class
	// The slot decoder sets at most one of them
	typedef struct packed {
		logic bsr;
		logic bra;
		logic jsr;
		logic jmp;
		logic bcc;
		logic rtd;
	} ctl_class_t;

endpackage

//--- common/pipe_pkg.sv
package pipe_pkg;

	// ==================================================
	// Addresses
	// ==================================================

	// Fetch address tagged with its stream
	typedef struct packed {
		logic [4:0]  stream;
		logic [31:0] pc;
	} pc_addr_t;

	// PC step from one slot to the next, in bytes
	localparam int INSN_BYTES = 6;

	// Slots held in a registered group
	// Stages narrower than this leave the upper slots cleared
	localparam int GRP_SLOTS = 4;

	// ==================================================
	// Pipeline slot and group
	// ==================================================

	typedef struct packed {
		// Slot holds a real instruction
		logic              v;
		// NOP inserted by single step
		logic              ssm;
		// Squashed by branch miss
		logic              nop;
		isa_pkg::instr_t   insn;
		pc_addr_t          pc;
		// Parcel index of the slot on the cache line
		logic [4:0]        cli;
		// Fetch predictor said taken
		logic              bt;
		// Slot number within the group
		logic [1:0]        wh;
	} slot_t;

	typedef struct packed {
		logic        v;
		// Hardware interrupt pending with this group
		logic        hwi;
		logic [5:0]  ipl;
		logic        flush;
		// Fetch PC of slot 0
		logic [31:0] ip;
	} group_hdr_t;

	typedef struct packed {
		group_hdr_t                  hdr;
		slot_t [GRP_SLOTS-1:0]       slots;
	} group_t;

	// ==================================================
	// Front-end redirect
	// ==================================================

	typedef struct packed {
		pc_addr_t new_address;
		pc_addr_t ret_pc;
		logic     do_call;
		logic     do_ret;
		// Fetch predictor was wrong about the next address
		logic     p_override;
		// Not-predicted conditional branch opens a new stream
		logic     alloc_stream;
	} redirect_t;

endpackage

//--- design/ext_line_aligner.sv
module ext_line_aligner import isa_pkg::*; import pipe_pkg::*; #(
	parameter int MWIDTH    = 4,
	parameter int LINE_BITS = 512
) (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  en_i,
	input  logic [LINE_BITS-1:0]  line_i,
	input  pc_addr_t              pc0_i,
	input  logic [MWIDTH-1:0]     takb_i,
	input  logic                  irq_i,
	input  logic                  stomp_i,
	input  logic                  ssm_i,
	output slot_t [MWIDTH-1:0]    slots_o
);

	// Aligned group is MWIDTH slots of three parcels
	localparam int GRP_BITS = MWIDTH * 48;
	localparam int PARCELS  = LINE_BITS / 16;
	localparam int OFF_W    = $clog2(PARCELS);

	logic [LINE_BITS+GRP_BITS-1:0] padded;
	logic [GRP_BITS-1:0]           aligned;
	logic [GRP_BITS-1:0]           prev_aligned;
	logic [OFF_W-1:0]              poff;
	pc_addr_t                      prev_pc;
	logic                          prev_v;
	logic                          prev_ssm;
	logic                          redundant;
	logic                          ssm_rise;

	// ==================================================
	// Line alignment
	// ==================================================

	// Parcel offset of the fetch PC within the line
	assign poff = pc0_i.pc[OFF_W:1];

	// Enough NOP parcels above the line to fill a whole group
	assign padded = {{(MWIDTH * 3){NOP_PARCEL}}, line_i};

	// Shift by 16 bits per parcel and keep the low slots
	assign aligned = GRP_BITS'(padded >> {poff, 4'd0});

	// ==================================================
	// Previous-group state
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			prev_v       <= 1'b0;
			prev_pc      <= '0;
			prev_aligned <= '0;
			prev_ssm     <= 1'b0;
		end else if (en_i) begin
			prev_v       <= 1'b1;
			prev_pc      <= pc0_i;
			prev_aligned <= aligned;
			prev_ssm     <= ssm_i;
		end
	end

	// Same PC and same bits as last time means fetch replayed the group
	assign redundant = prev_v && (prev_pc == pc0_i) && (prev_aligned == aligned);

	// First cycle of single step
	assign ssm_rise = ssm_i && !prev_ssm;

	// ==================================================
	// Slot build
	// ==================================================

	always_comb begin
		logic [31:0] spc;
		spc = '0;
		for (int n = 0; n < MWIDTH; n++) begin
			spc = pc0_i.pc + 32'(n * INSN_BYTES);
			slots_o[n].pc.stream = pc0_i.stream;
			slots_o[n].pc.pc     = spc;
			// Index is in parcels and wraps past the line end
			slots_o[n].cli       = 5'(spc[OFF_W:1]);
			slots_o[n].bt        = takb_i[n];
			slots_o[n].wh        = 2'(n);
			slots_o[n].nop       = 1'b0;
			slots_o[n].ssm       = 1'b0;
			slots_o[n].insn      = instr_t'(aligned[n*48 +: 48]);
			if (redundant) begin
				slots_o[n].insn = NOP_INSN;
			end else if (ssm_i && !(n == 0 && ssm_rise)) begin
				// Single step lets slot 0 through once and the rest step out
				slots_o[n].insn = NOP_INSN;
				slots_o[n].ssm  = 1'b1;
			end
			// Interrupt or stomp kills everything
			if (n == 0)
				slots_o[n].v = !redundant && !irq_i && !stomp_i && (!ssm_i || ssm_rise);
			else
				slots_o[n].v = !redundant && !irq_i && !stomp_i && !ssm_i;
		end
	end

	// Slot 0 issues only once in a single-step run
	a_ssm_single : assert property (@(posedge clk) disable iff (rst_i)
		($past(en_i && ssm_i && !rst_i) && ssm_i) |-> !slots_o[0].v);

endmodule

//--- design/ext_slot_decode.sv
module ext_slot_decode import isa_pkg::*; import pipe_pkg::*; #(
	parameter logic [31:0] RSTPC = 32'hFFFC_0100
) (
	input  slot_t       slot_i,
	input  logic        branchmiss_i,
	input  pc_addr_t    misspc_i,
	output slot_t       slot_o,
	output ctl_class_t  cls_o,
	output logic [31:0] tgt_o
);

	logic [31:0] rel_tgt;
	logic [31:0] abs_tgt;
	logic        is_rel;
	logic        is_abs;

	// ==================================================
	// Transfer class
	// ==================================================

	// Valid bit is ignored here
	// Squashed slots are handled when the group is registered
	always_comb begin
		cls_o = '0;
		case (slot_i.insn.opcode)
			OP_BSR:  cls_o.bsr = 1'b1;
			OP_BRA:  cls_o.bra = 1'b1;
			OP_JSR:  cls_o.jsr = 1'b1;
			OP_JMP:  cls_o.jmp = 1'b1;
			OP_BCC:  cls_o.bcc = 1'b1;
			OP_RTD:  cls_o.rtd = 1'b1;
			default: cls_o = '0;
		endcase
	end

	// ==================================================
	// Target address
	// ==================================================

	// Only the low 32 bits of the byte displacement matter modulo the address space
	assign rel_tgt = slot_i.pc.pc + slot_i.insn.operand[31:0];

	// Absolute target lives in the low operand bits
	assign abs_tgt = slot_i.insn.operand[31:0];

	assign is_rel = cls_o.bsr || cls_o.bra || cls_o.bcc;
	assign is_abs = cls_o.jsr || cls_o.jmp;

	// Non-transfers point at the reset vector and are never selected
	always_comb begin
		if (is_rel)
			tgt_o = rel_tgt;
		else if (is_abs)
			tgt_o = abs_tgt;
		else
			tgt_o = RSTPC;
	end

	// ==================================================
	// Branch-miss squash
	// ==================================================

	// Slots before the miss PC already ran on the other path
	always_comb begin
		slot_o     = slot_i;
		slot_o.nop = branchmiss_i && (misspc_i.pc > slot_i.pc.pc);
	end

endmodule

//--- design/ext_group_select.sv
module ext_group_select import isa_pkg::*; import pipe_pkg::*; #(
	parameter int          MWIDTH = 4,
	parameter logic [31:0] RSTPC  = 32'hFFFC_0100
) (
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic                      en_i,
	input  slot_t [MWIDTH-1:0]        slots_i,
	input  ctl_class_t [MWIDTH-1:0]   cls_i,
	input  logic [MWIDTH-1:0][31:0]   tgts_i,
	input  pc_addr_t                  pc0_i,
	input  logic [MWIDTH-1:0]         pt_i,
	input  logic [4:0]                new_stream_i,
	input  logic                      irq_i,
	input  logic [5:0]                ipl_i,
	input  logic                      stomp_i,
	input  logic                      flush_i,
	output redirect_t                 redirect_o,
	output group_t                    group_o,
	output logic                      nop_o,
	output logic [MWIDTH-1:0]         pt_dec_o
);

	logic [MWIDTH-1:0] xfer;
	logic [MWIDTH-1:0] call;
	logic [MWIDTH-1:0] ret;
	logic              any_xfer;
	logic [1:0]        sel;
	group_t            grp_d;

	// ==================================================
	// Transfer priority
	// ==================================================

	// Return alone does not redirect here
	always_comb begin
		for (int n = 0; n < MWIDTH; n++) begin
			xfer[n] = cls_i[n].bsr || cls_i[n].bra || cls_i[n].jsr ||
			          cls_i[n].jmp || cls_i[n].bcc;
			call[n] = cls_i[n].bsr || cls_i[n].jsr;
			ret[n]  = cls_i[n].rtd;
		end
	end

	assign any_xfer = |xfer;

	// Lowest slot wins when scanning from the top down
	always_comb begin
		sel = '0;
		for (int n = MWIDTH - 1; n >= 0; n--)
			if (xfer[n])
				sel = 2'(n);
	end

	// ==================================================
	// Redirect
	// ==================================================

	always_comb begin
		redirect_o = '0;
		if (any_xfer) begin
			redirect_o.new_address.pc = tgts_i[sel];
			// Not-predicted conditional gets a fresh stream
			if (cls_i[sel].bcc && !pt_i[sel]) begin
				redirect_o.new_address.stream = new_stream_i;
				redirect_o.alloc_stream       = 1'b1;
			end else begin
				redirect_o.new_address.stream = pc0_i.stream;
			end
		end else begin
			redirect_o.new_address = pc_addr_t'{stream: 5'd1, pc: RSTPC};
		end

		// Return address follows the first call
		redirect_o.ret_pc = pc_addr_t'{stream: 5'd1, pc: RSTPC};
		for (int n = MWIDTH - 1; n >= 0; n--) begin
			if (call[n]) begin
				redirect_o.ret_pc.stream = pc0_i.stream;
				redirect_o.ret_pc.pc     = slots_i[n].pc.pc + 32'(INSN_BYTES);
			end
		end

		redirect_o.do_call    = |call;
		redirect_o.do_ret     = |ret;
		redirect_o.p_override = any_xfer && (redirect_o.new_address.pc != pc0_i.pc);
	end

	// ==================================================
	// Output group
	// ==================================================

	always_comb begin
		grp_d           = '0;
		grp_d.hdr.v     = !stomp_i;
		grp_d.hdr.hwi   = irq_i;
		grp_d.hdr.ipl   = ipl_i;
		grp_d.hdr.flush = flush_i;
		grp_d.hdr.ip    = pc0_i.pc;
		// Upper slots stay cleared in a narrow stage
		for (int n = 0; n < MWIDTH; n++) begin
			grp_d.slots[n] = slots_i[n];
			// Squashed slot turns into a dead NOP
			if (slots_i[n].nop) begin
				grp_d.slots[n].insn = NOP_INSN;
				grp_d.slots[n].v    = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			group_o.hdr.v <= 1'b0;
			for (int n = 0; n < GRP_SLOTS; n++)
				group_o.slots[n].v <= 1'b0;
			nop_o    <= 1'b0;
			pt_dec_o <= '0;
		end else if (en_i) begin
			group_o  <= grp_d;
			// Whole group stomped
			nop_o    <= stomp_i;
			pt_dec_o <= pt_i;
		end
	end

	// New stream only when the chosen slot really holds a conditional branch
	a_alloc_bcc : assert property (@(posedge clk) disable iff (rst_i)
		redirect_o.alloc_stream |-> (slots_i[sel].insn.opcode == OP_BCC));

endmodule

//--- design/ext_stage_top.sv
module ext_stage_top import isa_pkg::*; import pipe_pkg::*; #(
	parameter int          MWIDTH    = 4,
	parameter int          LINE_BITS = 512,
	parameter logic [31:0] RSTPC     = 32'hFFFC_0100
) (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  en_i,
	input  logic [LINE_BITS-1:0]  line_i,
	input  pc_addr_t              pc0_i,
	input  logic [MWIDTH-1:0]     takb_i,
	input  logic [MWIDTH-1:0]     pt_i,
	input  logic                  irq_i,
	input  logic [5:0]            ipl_i,
	input  logic                  stomp_i,
	input  logic                  ssm_i,
	input  logic                  flush_i,
	input  logic                  branchmiss_i,
	input  pc_addr_t              misspc_i,
	input  logic [4:0]            new_stream_i,
	input  logic                  mux_stall_i,
	output redirect_t             redirect_o,
	output group_t                group_o,
	output logic                  nop_o,
	output logic [MWIDTH-1:0]     pt_dec_o,
	output logic                  fet_stall_o
);

	slot_t [MWIDTH-1:0]      align_slots;
	slot_t [MWIDTH-1:0]      dec_slots;
	ctl_class_t [MWIDTH-1:0] cls;
	logic [MWIDTH-1:0][31:0] tgts;

	// Line to slots
	ext_line_aligner #(
		.MWIDTH    (MWIDTH),
		.LINE_BITS (LINE_BITS)
	) u_align (
		.clk     (clk),
		.rst_i   (rst_i),
		.en_i    (en_i),
		.line_i  (line_i),
		.pc0_i   (pc0_i),
		.takb_i  (takb_i),
		.irq_i   (irq_i),
		.stomp_i (stomp_i),
		.ssm_i   (ssm_i),
		.slots_o (align_slots)
	);

	// One transfer decoder per slot
	for (genvar g = 0; g < MWIDTH; g++) begin : g_dec
		ext_slot_decode #(
			.RSTPC (RSTPC)
		) u_dec (
			.slot_i       (align_slots[g]),
			.branchmiss_i (branchmiss_i),
			.misspc_i     (misspc_i),
			.slot_o       (dec_slots[g]),
			.cls_o        (cls[g]),
			.tgt_o        (tgts[g])
		);
	end

	// Redirect and group register
	ext_group_select #(
		.MWIDTH (MWIDTH),
		.RSTPC  (RSTPC)
	) u_sel (
		.clk          (clk),
		.rst_i        (rst_i),
		.en_i         (en_i),
		.slots_i      (dec_slots),
		.cls_i        (cls),
		.tgts_i       (tgts),
		.pc0_i        (pc0_i),
		.pt_i         (pt_i),
		.new_stream_i (new_stream_i),
		.irq_i        (irq_i),
		.ipl_i        (ipl_i),
		.stomp_i      (stomp_i),
		.flush_i      (flush_i),
		.redirect_o   (redirect_o),
		.group_o      (group_o),
		.nop_o        (nop_o),
		.pt_dec_o     (pt_dec_o)
	);

	// Mux stall goes straight back to fetch
	assign fet_stall_o = mux_stall_i;

endmodule

//--- bench/ext_model.svh
`ifndef EXT_MODEL_SVH
`define EXT_MODEL_SVH

// ==================================================
// Reference model of the extract stage
// ==================================================

// Everything fetch presents in one cycle
typedef struct packed {
	logic            en;
	logic [LB-1:0]   line;
	pc_addr_t        pc0;
	logic [MW-1:0]   takb;
	logic [MW-1:0]   pt;
	logic            irq;
	logic [5:0]      ipl;
	logic            stomp;
	logic            ssm;
	logic            flush;
	logic            branchmiss;
	pc_addr_t        misspc;
	logic [4:0]      new_stream;
	logic            mux_stall;
} stim_t;

typedef slot_t [MW-1:0] slot_vec_t;

// State of the last enabled cycle
logic            m_prev_v;
pc_addr_t        m_prev_pc;
logic [GB-1:0]   m_prev_bits;
logic            m_prev_ssm;

function automatic void model_reset();
	m_prev_v    = 1'b0;
	m_prev_pc   = '0;
	m_prev_bits = '0;
	m_prev_ssm  = 1'b0;
endfunction

// Parcels from the PC offset upward, NOP parcels past the line end
function automatic logic [GB-1:0] align_bits(logic [LB-1:0] line, logic [31:0] pc);
	logic [GB-1:0] bits;
	int            p;
	for (int k = 0; k < MW * 3; k++) begin
		// Parcel offset is pc[5:1] for a 512-bit line
		p = int'(pc[5:1]) + k;
		bits[k*16 +: 16] = (p < PARCELS) ? line[p*16 +: 16] : NOP_PARCEL;
	end
	return bits;
endfunction

function automatic void model_advance(stim_t s);
	m_prev_v    = 1'b1;
	m_prev_pc   = s.pc0;
	m_prev_bits = align_bits(s.line, s.pc0.pc);
	m_prev_ssm  = s.ssm;
endfunction

// Slots as the decoders hand them on
function automatic slot_vec_t model_slots(stim_t s);
	slot_vec_t     sv;
	logic [GB-1:0] bits;
	logic          red;
	logic          rise;
	logic [31:0]   spc;
	bits = align_bits(s.line, s.pc0.pc);
	red  = m_prev_v && (m_prev_pc == s.pc0) && (m_prev_bits == bits);
	rise = s.ssm && !m_prev_ssm;
	for (int n = 0; n < MW; n++) begin
		spc             = s.pc0.pc + 32'(INSN_BYTES * n);
		sv[n]           = '0;
		sv[n].pc.stream = s.pc0.stream;
		sv[n].pc.pc     = spc;
		sv[n].cli       = spc[5:1];
		sv[n].bt        = s.takb[n];
		sv[n].wh        = 2'(n);
		sv[n].insn      = instr_t'(bits[n*48 +: 48]);
		if (red) begin
			sv[n].insn = instr_t'({3{NOP_PARCEL}});
		end else if (s.ssm && !(n == 0 && rise)) begin
			sv[n].insn = instr_t'({3{NOP_PARCEL}});
			sv[n].ssm  = 1'b1;
		end
		// Slot 0 may pass on the first single-step cycle
		if (n == 0)
			sv[n].v = !red && !s.irq && !s.stomp && (!s.ssm || rise);
		else
			sv[n].v = !red && !s.irq && !s.stomp && !s.ssm;
		sv[n].nop = s.branchmiss && (s.misspc.pc > spc);
	end
	return sv;
endfunction

function automatic ctl_class_t classify(opcode_t op);
	ctl_class_t c;
	c = '0;
	case (op)
		OP_BSR:  c.bsr = 1'b1;
		OP_BRA:  c.bra = 1'b1;
		OP_JSR:  c.jsr = 1'b1;
		OP_JMP:  c.jmp = 1'b1;
		OP_BCC:  c.bcc = 1'b1;
		OP_RTD:  c.rtd = 1'b1;
		default: c = '0;
	endcase
	return c;
endfunction

function automatic redirect_t model_redirect(stim_t s, slot_vec_t sv);
	redirect_t  r;
	ctl_class_t c;
	logic       found;
	logic [31:0] tgt;
	r             = '0;
	found         = 1'b0;
	r.new_address = '{stream: 5'd1, pc: RST_PC};
	r.ret_pc      = '{stream: 5'd1, pc: RST_PC};
	for (int n = 0; n < MW; n++) begin
		c = classify(sv[n].insn.opcode);
		if (c.rtd)
			r.do_ret = 1'b1;
		// First call gives the return address
		if ((c.bsr || c.jsr) && !r.do_call) begin
			r.do_call   = 1'b1;
			r.ret_pc    = '{stream: s.pc0.stream, pc: sv[n].pc.pc + 32'(INSN_BYTES)};
		end
		if (!found && (c.bsr || c.bra || c.jsr || c.jmp || c.bcc)) begin
			found = 1'b1;
			// Low word of the sign-extended displacement is enough mod 2^32
			if (c.jsr || c.jmp)
				tgt = sv[n].insn.operand[31:0];
			else
				tgt = sv[n].pc.pc + sv[n].insn.operand[31:0];
			r.new_address.pc = tgt;
			if (c.bcc && !s.pt[n]) begin
				r.new_address.stream = s.new_stream;
				r.alloc_stream       = 1'b1;
			end else begin
				r.new_address.stream = s.pc0.stream;
			end
			r.p_override = (tgt != s.pc0.pc);
		end
	end
	return r;
endfunction

function automatic group_t model_group(stim_t s, slot_vec_t sv);
	group_t g;
	g           = '0;
	g.hdr.v     = !s.stomp;
	g.hdr.hwi   = s.irq;
	g.hdr.ipl   = s.ipl;
	g.hdr.flush = s.flush;
	g.hdr.ip    = s.pc0.pc;
	for (int n = 0; n < MW; n++) begin
		g.slots[n] = sv[n];
		// Branch-miss squash leaves a dead NOP
		if (sv[n].nop) begin
			g.slots[n].insn = instr_t'({3{NOP_PARCEL}});
			g.slots[n].v    = 1'b0;
		end
	end
	return g;
endfunction

`endif

//--- bench/ext_stage_tb.sv
module ext_stage_tb import isa_pkg::*; import pipe_pkg::*; ();

	localparam int          MW         = 4;
	localparam int          LB         = 512;
	localparam int          GB         = MW * 48;
	localparam int          PARCELS    = LB / 16;
	localparam logic [31:0] RST_PC     = 32'hFFFC_0100;
	localparam int          NUM_GROUPS = 400;
	// Cycles allowed for any single wait
	localparam int          WAIT_LIMIT = 12;

	`include "ext_model.svh"

	logic            clk = 1'b0;
	logic            rst_i;
	logic            en_i;
	logic [LB-1:0]   line_i;
	pc_addr_t        pc0_i;
	logic [MW-1:0]   takb_i;
	logic [MW-1:0]   pt_i;
	logic            irq_i;
	logic [5:0]      ipl_i;
	logic            stomp_i;
	logic            ssm_i;
	logic            flush_i;
	logic            branchmiss_i;
	pc_addr_t        misspc_i;
	logic [4:0]      new_stream_i;
	logic            mux_stall_i;
	redirect_t       redirect_o;
	group_t          group_o;
	logic            nop_o;
	logic [MW-1:0]   pt_dec_o;
	logic            fet_stall_o;

	ext_stage_top #(
		.MWIDTH    (MW),
		.LINE_BITS (LB),
		.RSTPC     (RST_PC)
	) u_dut (
		.clk          (clk),
		.rst_i        (rst_i),
		.en_i         (en_i),
		.line_i       (line_i),
		.pc0_i        (pc0_i),
		.takb_i       (takb_i),
		.pt_i         (pt_i),
		.irq_i        (irq_i),
		.ipl_i        (ipl_i),
		.stomp_i      (stomp_i),
		.ssm_i        (ssm_i),
		.flush_i      (flush_i),
		.branchmiss_i (branchmiss_i),
		.misspc_i     (misspc_i),
		.new_stream_i (new_stream_i),
		.mux_stall_i  (mux_stall_i),
		.redirect_o   (redirect_o),
		.group_o      (group_o),
		.nop_o        (nop_o),
		.pt_dec_o     (pt_dec_o),
		.fet_stall_o  (fet_stall_o)
	);

	always #50 clk = ~clk;

	// ==================================================
	// Failure and compare tasks
	// ==================================================

	task automatic fail_run();
		$display("tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_redirect(redirect_t exp);
		if (redirect_o !== exp) begin
			$display("ERR t=%0t redirect_o exp=%h got=%h", $time, exp, redirect_o);
			fail_run();
		end
	endtask

	task automatic check_group(group_t exp);
		if (group_o !== exp) begin
			$display("ERR t=%0t group_o exp=%h got=%h", $time, exp, group_o);
			fail_run();
		end
	endtask

	// Only the valid bits are defined straight after reset
	task automatic check_valid_bits(logic exp_hv, logic [GRP_SLOTS-1:0] exp_sv);
		logic [GRP_SLOTS-1:0] got;
		for (int n = 0; n < GRP_SLOTS; n++)
			got[n] = group_o.slots[n].v;
		if (group_o.hdr.v !== exp_hv || got !== exp_sv) begin
			$display("ERR t=%0t group_o valid bits exp=%b_%b got=%b_%b", $time,
				exp_hv, exp_sv, group_o.hdr.v, got);
			fail_run();
		end
	endtask

	task automatic check_ctl(logic exp_nop, logic [MW-1:0] exp_pt, logic exp_stall);
		if (nop_o !== exp_nop) begin
			$display("ERR t=%0t nop_o exp=%b got=%b", $time, exp_nop, nop_o);
			fail_run();
		end
		if (pt_dec_o !== exp_pt) begin
			$display("ERR t=%0t pt_dec_o exp=%b got=%b", $time, exp_pt, pt_dec_o);
			fail_run();
		end
		if (fet_stall_o !== exp_stall) begin
			$display("ERR t=%0t fet_stall_o exp=%b got=%b", $time, exp_stall, fet_stall_o);
			fail_run();
		end
	endtask

	// ==================================================
	// Stimulus
	// ==================================================

	// Weighted opcode mix with frequent transfers
	function automatic logic [47:0] rand_insn();
		opcode_t op;
		case ($urandom_range(11, 0))
			0, 1, 2: op = opcode_t'($urandom_range(127, 0));
			3:       op = OP_NOP;
			4:       op = OP_BSR;
			5:       op = OP_BRA;
			6:       op = OP_JSR;
			7:       op = OP_JMP;
			8, 9:    op = OP_BCC;
			default: op = OP_RTD;
		endcase
		return {8'($urandom), 32'($urandom), 1'b0, op};
	endfunction

	function automatic stim_t new_fetch(stim_t prev);
		stim_t       s;
		int          poff;
		int          p;
		logic [47:0] ins;
		s = prev;
		// Now and then replay the last PC and line
		if ($urandom_range(5, 0) != 0) begin
			for (int k = 0; k < LB / 32; k++)
				s.line[k*32 +: 32] = $urandom;
			// Bias toward the line end to get padding
			if ($urandom_range(1, 0) == 1)
				poff = $urandom_range(31, 22);
			else
				poff = $urandom_range(31, 0);
			s.pc0.pc      = $urandom;
			s.pc0.pc[5:0] = {5'(poff), 1'b0};
			s.pc0.stream  = 5'($urandom);
			// Real instructions on each slot boundary
			for (int n = 0; n < MW; n++) begin
				ins = rand_insn();
				for (int j = 0; j < 3; j++) begin
					p = poff + 3 * n + j;
					if (p < PARCELS)
						s.line[p*16 +: 16] = ins[j*16 +: 16];
				end
			end
		end
		s.takb       = MW'($urandom);
		s.pt         = MW'($urandom);
		s.irq        = ($urandom_range(7, 0) == 0);
		s.ipl        = 6'($urandom);
		s.stomp      = ($urandom_range(7, 0) == 0);
		s.flush      = ($urandom_range(7, 0) == 0);
		// Single step comes in runs
		s.ssm        = s.ssm ^ ($urandom_range(4, 0) == 0);
		s.branchmiss = ($urandom_range(3, 0) == 0);
		s.misspc.pc  = s.pc0.pc + $urandom_range(30, 0);
		s.misspc.stream = 5'($urandom);
		s.new_stream = 5'($urandom);
		return s;
	endfunction

	task automatic drive_inputs(stim_t s);
		en_i         <= s.en;
		line_i       <= s.line;
		pc0_i        <= s.pc0;
		takb_i       <= s.takb;
		pt_i         <= s.pt;
		irq_i        <= s.irq;
		ipl_i        <= s.ipl;
		stomp_i      <= s.stomp;
		ssm_i        <= s.ssm;
		flush_i      <= s.flush;
		branchmiss_i <= s.branchmiss;
		misspc_i     <= s.misspc;
		new_stream_i <= s.new_stream;
		mux_stall_i  <= s.mux_stall;
	endtask

	task automatic wait_reset_release();
		int k;
		for (k = 0; k < WAIT_LIMIT; k++) begin
			@(negedge clk);
			if (rst_i === 1'b0)
				break;
		end
		if (k == WAIT_LIMIT) begin
			$display("timeout while waiting for reset to be released");
			fail_run();
		end
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		stim_t         cur;
		slot_vec_t     msl;
		group_t        exp_grp;
		logic          exp_nop;
		logic [MW-1:0] exp_pt;
		logic          grp_known;
		logic          done;
		void'($urandom(38481));
		cur       = '0;
		exp_grp   = '0;
		exp_nop   = 1'b0;
		exp_pt    = '0;
		grp_known = 1'b0;
		model_reset();
		rst_i = 1'b1;
		drive_inputs(cur);
		repeat (2) @(posedge clk);
		rst_i <= 1'b0;
		wait_reset_release();
		check_valid_bits(1'b0, '0);
		check_ctl(1'b0, '0, 1'b0);

		for (int t = 0; t < NUM_GROUPS; t++) begin
			cur  = new_fetch(cur);
			done = 1'b0;
			// Hold the fetch inputs until an enabled edge takes them
			for (int k = 0; k < WAIT_LIMIT && !done; k++) begin
				@(posedge clk);
				cur.en        = (k >= 3) || ($urandom_range(3, 0) != 0);
				cur.mux_stall = 1'($urandom_range(1, 0));
				drive_inputs(cur);
				@(negedge clk);
				msl = model_slots(cur);
				check_redirect(model_redirect(cur, msl));
				if (grp_known) begin
					check_group(exp_grp);
					check_ctl(exp_nop, exp_pt, cur.mux_stall);
				end else begin
					check_valid_bits(1'b0, '0);
					check_ctl(1'b0, '0, cur.mux_stall);
				end
				if (cur.en) begin
					exp_grp   = model_group(cur, msl);
					exp_nop   = cur.stomp;
					exp_pt    = cur.pt;
					grp_known = 1'b1;
					model_advance(cur);
					done      = 1'b1;
				end
			end
			if (!done) begin
				$display("timeout while waiting for an enabled clock edge");
				fail_run();
			end
		end

		// Last group shows after one more edge with enable low
		@(posedge clk);
		cur.en = 1'b0;
		drive_inputs(cur);
		@(negedge clk);
		check_group(exp_grp);
		check_ctl(exp_nop, exp_pt, cur.mux_stall);

		$display("all tests passed");
		$finish;
	end

endmodule

//--- compile.f
+incdir+bench
common/isa_pkg.sv
common/pipe_pkg.sv
design/ext_line_aligner.sv
design/ext_slot_decode.sv
design/ext_group_select.sv
design/ext_stage_top.sv
bench/ext_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the extract stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module ext_stage_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
	echo "FAIL: Verilator build did not complete"
	exit 1
fi

./obj_dir/Vext_stage_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "FAIL: simulation exited with status $status"
	exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
	exit 0
fi
echo "FAIL: pass line not found in $LOG"
exit 1
